//--- design/fe_instr_pkg.sv
package fe_instr_pkg;

    // Byte address of an instruction
    typedef logic [31:0] t_pc;

    // Raw 32-bit RISC-V encoding
    typedef logic [31:0] t_rv_instr;

    // Bumped on each redirect, tags in-flight requests
    typedef logic [1:0] t_epoch;

    // Packet handed to decode
    typedef struct packed {
        t_pc       pc;
        t_rv_instr instr;
    } t_instr_pkt;

    // Mispredict or nuke target
    typedef struct packed {
        logic valid;
        t_pc  pc;
    } t_redirect_pkt;

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_RUN,
        FE_HALT
    } t_fe_state;

    // Straight-line fetch step
    localparam t_pc PC_STEP = 32'd4;

    // APB register map
    localparam int APB_AW = 8;
    localparam logic [APB_AW-1:0] CSR_CTRL     = 8'h00;
    localparam logic [APB_AW-1:0] CSR_RESET_PC = 8'h04;
    localparam logic [APB_AW-1:0] CSR_MISSES   = 8'h08;

    // CTRL bit fields
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_FLUSH  = 1;

endpackage

//--- design/fe_mem_pkg.sv
package fe_mem_pkg;

    localparam int ADDR_W          = 32;
    localparam int LINE_BYTES      = 16;
    localparam int INSTRS_PER_LINE = 4;
    localparam int IC_SETS         = 8;

    // Derived geometry
    localparam int LINE_OFF_W  = $clog2(LINE_BYTES);
    localparam int WORD_SEL_W  = $clog2(INSTRS_PER_LINE);
    localparam int LINE_ADDR_W = ADDR_W - LINE_OFF_W;
    localparam int IC_IDX_W    = $clog2(IC_SETS);
    localparam int IC_TAG_W    = LINE_ADDR_W - IC_IDX_W;

    // Line address as sent to L2
    typedef logic [LINE_ADDR_W-1:0] t_line_addr;

    // Word k sits in bits 32k+31:32k
    typedef logic [INSTRS_PER_LINE*32-1:0] t_line_data;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_MISS,
        IC_FILL
    } t_ic_state;

endpackage

//--- design/fe_if.sv
`timescale 1ns/1ps

// PC request from the fetch controller into the buffer
interface fe_fetch_if import fe_instr_pkg::*; ();

    logic   req_valid;
    t_pc    req_pc;
    t_epoch req_epoch;
    logic   req_ready;
    // Flushes the buffer and its output
    logic   redirect;

    modport ctl (
        output req_valid, req_pc, req_epoch, redirect,
        input  req_ready
    );

    modport fbuf (
        input  req_valid, req_pc, req_epoch, redirect,
        output req_ready
    );

endinterface

// Line request from the buffer into the icache
interface fe_line_if import fe_mem_pkg::*; ();

    logic       req_valid;
    t_line_addr req_line;
    logic       req_ready;
    // Single-cycle pulse per request
    logic       rsp_valid;
    t_line_data rsp_data;

    modport fbuf (
        output req_valid, req_line,
        input  req_ready, rsp_valid, rsp_data
    );

    modport cache (
        input  req_valid, req_line,
        output req_ready, rsp_valid, rsp_data
    );

endinterface

//--- design/fe_ctl.sv
`timescale 1ns/1ps

module fe_ctl import fe_instr_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          enable,
    input  t_pc           reset_pc,
    input  t_redirect_pkt br_mispred,
    input  t_redirect_pkt nuke,
    input  logic          resume_fetch,
    fe_fetch_if.ctl       fetch
);

    t_fe_state state;
    t_pc       pc;
    t_epoch    epoch;
    logic      start;
    logic      redirect;
    logic      accept;

    // First cycle after enable rises
    assign start = (state == FE_IDLE) && enable;

    // Any PC discontinuity kills what the buffer holds
    assign redirect = br_mispred.valid || nuke.valid || start;

    // No request while the PC is being replaced
    assign fetch.req_valid = (state == FE_RUN) && !redirect;
    assign fetch.req_pc    = pc;
    assign fetch.req_epoch = epoch;
    assign fetch.redirect  = redirect;

    assign accept = fetch.req_valid && fetch.req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FE_IDLE;
            epoch <= '0;
        end else begin
            if (redirect) begin
                epoch <= epoch + 1'b1;
            end
            case (state)
                FE_IDLE: begin
                    if (enable) begin
                        state <= FE_RUN;
                    end
                end
                FE_RUN: begin
                    if (!enable) begin
                        state <= FE_IDLE;
                    end else if (nuke.valid) begin
                        state <= FE_HALT;
                    end
                end
                FE_HALT: begin
                    // Newer nuke keeps us parked
                    if (!enable) begin
                        state <= FE_IDLE;
                    end else if (resume_fetch && !nuke.valid) begin
                        state <= FE_RUN;
                    end
                end
                default: state <= FE_IDLE;
            endcase
        end
    end

    // PC update, nuke beats mispredict
    always_ff @(posedge clk) begin
        if (start) begin
            pc <= reset_pc;
        end else if (state != FE_IDLE && nuke.valid) begin
            pc <= nuke.pc;
        end else if (state == FE_RUN && br_mispred.valid) begin
            pc <= br_mispred.pc;
        end else if (accept) begin
            pc <= pc + PC_STEP;
        end
    end

    // Execute and retire must not redirect in the same cycle
    a_one_redirect: assert property (
        @(posedge clk) disable iff (rst)
        !(br_mispred.valid && nuke.valid)
    );

endmodule

//--- design/fe_buf.sv
`timescale 1ns/1ps

module fe_buf import fe_instr_pkg::*, fe_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    fe_fetch_if.fbuf   fetch,
    fe_line_if.fbuf    line,
    input  logic       decode_ready,
    output logic       valid_fe1,
    output t_instr_pkt instr_fe1
);

    logic                  line_valid;
    t_line_addr            line_tag;
    t_line_data            line_data;
    logic                  pend;
    t_line_addr            pend_line;
    t_epoch                pend_epoch;
    t_line_addr            req_line;
    logic [WORD_SEL_W-1:0] req_word;
    t_rv_instr             sel_instr;
    logic                  hit;
    logic                  hold;
    logic                  accept;
    logic                  line_fire;
    logic                  rsp_keep;

    // Split the requested PC
    assign req_line  = fetch.req_pc[ADDR_W-1:LINE_OFF_W];
    assign req_word  = fetch.req_pc[LINE_OFF_W-1:2];
    assign sel_instr = line_data[req_word*32 +: 32];

    assign hit  = line_valid && (line_tag == req_line);
    // Decode stall with something on the output
    assign hold = valid_fe1 && !decode_ready;

    assign fetch.req_ready = hit && !hold;
    assign accept          = fetch.req_valid && fetch.req_ready;

    // Miss goes out only with nothing in flight
    assign line.req_valid = fetch.req_valid && !hit && !pend;
    assign line.req_line  = req_line;
    assign line_fire      = line.req_valid && line.req_ready;

    // Epoch moved on, so the line is from before a redirect
    assign rsp_keep = line.rsp_valid && pend && (pend_epoch == fetch.req_epoch);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend       <= 1'b0;
            line_valid <= 1'b0;
            valid_fe1  <= 1'b0;
        end else begin
            if (line_fire) begin
                pend <= 1'b1;
            end else if (line.rsp_valid) begin
                pend <= 1'b0;
            end

            if (fetch.redirect) begin
                line_valid <= 1'b0;
            end else if (rsp_keep) begin
                line_valid <= 1'b1;
            end

            if (fetch.redirect) begin
                valid_fe1 <= 1'b0;
            end else if (accept) begin
                valid_fe1 <= 1'b1;
            end else if (!hold) begin
                valid_fe1 <= 1'b0;
            end
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        if (line_fire) begin
            pend_line  <= req_line;
            pend_epoch <= fetch.req_epoch;
        end
        if (rsp_keep) begin
            line_tag  <= pend_line;
            line_data <= line.rsp_data;
        end
        if (accept) begin
            instr_fe1.pc    <= fetch.req_pc;
            instr_fe1.instr <= sel_instr;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (valid_fe1 && !decode_ready) |=> $stable(instr_fe1)
    );

endmodule

//--- design/icache.sv
`timescale 1ns/1ps

module icache import fe_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    fe_line_if.cache   line,
    output logic       l2_req_valid,
    output t_line_addr l2_req_line,
    input  logic       l2_rsp_valid,
    input  t_line_data l2_rsp_data,
    output logic       miss
);

    t_ic_state             state;
    logic [IC_TAG_W-1:0]   tag_mem [IC_SETS];
    t_line_data            data_mem [IC_SETS];
    logic [IC_SETS-1:0]    valid_q;
    t_line_addr            lk_line;
    logic [IC_TAG_W-1:0]   rd_tag;
    logic                  rd_valid;
    t_line_data            rd_data;
    t_line_data            rsp_data_q;
    logic                  l2_req_q;
    logic [IC_IDX_W-1:0]   req_idx;
    logic [IC_IDX_W-1:0]   lk_idx;
    logic [IC_TAG_W-1:0]   lk_tag;
    logic                  accept;
    logic                  hit;
    logic                  fill;

    assign req_idx = line.req_line[IC_IDX_W-1:0];
    assign lk_idx  = lk_line[IC_IDX_W-1:0];
    assign lk_tag  = lk_line[LINE_ADDR_W-1:IC_IDX_W];

    assign line.req_ready = (state == IC_IDLE);
    assign accept         = line.req_valid && line.req_ready;

    // Compare against the tag read last cycle
    assign hit  = rd_valid && (rd_tag == lk_tag);
    assign fill = (state == IC_MISS) && l2_rsp_valid;

    // IC_FILL is the response cycle for both hit and refill
    assign line.rsp_valid = (state == IC_FILL);
    assign line.rsp_data  = rsp_data_q;

    assign l2_req_valid = l2_req_q;
    assign l2_req_line  = lk_line;
    assign miss         = l2_req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IC_IDLE;
            valid_q  <= '0;
            l2_req_q <= 1'b0;
        end else begin
            l2_req_q <= 1'b0;
            case (state)
                IC_IDLE: begin
                    if (accept) begin
                        state <= IC_LOOKUP;
                    end
                end
                IC_LOOKUP: begin
                    if (hit) begin
                        state <= IC_FILL;
                    end else begin
                        state    <= IC_MISS;
                        l2_req_q <= 1'b1;
                    end
                end
                IC_MISS: begin
                    if (l2_rsp_valid) begin
                        state <= IC_FILL;
                    end
                end
                default: state <= IC_IDLE;
            endcase
            if (fill) begin
                valid_q[lk_idx] <= 1'b1;
            end
            // Flush wins over a fill in the same cycle
            if (flush) begin
                valid_q <= '0;
            end
        end
    end

    // Arrays and read registers
    always_ff @(posedge clk) begin
        if (accept) begin
            lk_line  <= line.req_line;
            rd_tag   <= tag_mem[req_idx];
            rd_data  <= data_mem[req_idx];
            rd_valid <= valid_q[req_idx];
        end
        if (state == IC_LOOKUP && hit) begin
            rsp_data_q <= rd_data;
        end
        if (fill) begin
            tag_mem[lk_idx]  <= lk_tag;
            data_mem[lk_idx] <= l2_rsp_data;
            rsp_data_q       <= l2_rsp_data;
        end
    end

    // L2 answers only the one miss we sent
    a_l2_rsp_in_miss: assert property (
        @(posedge clk) disable iff (rst)
        l2_rsp_valid |-> (state == IC_MISS)
    );

endmodule

//--- design/fe_csr.sv
`timescale 1ns/1ps

module fe_csr import fe_instr_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    input  logic              miss,
    output logic              enable,
    output logic              flush,
    output t_pc               reset_pc
);

    logic        wr_en;
    logic        rd_en;
    logic [31:0] miss_cnt;
    logic [31:0] rd_mux;

    // Zero wait states
    assign pready = 1'b1;

    // Write lands at end of access, read captured in setup
    assign wr_en = psel && penable && pwrite;
    assign rd_en = psel && !penable && !pwrite;

    always_comb begin
        rd_mux = '0;
        case (paddr)
            // Flush bit always reads 0
            CSR_CTRL:     rd_mux[CTRL_ENABLE] = enable;
            CSR_RESET_PC: rd_mux = reset_pc;
            CSR_MISSES:   rd_mux = miss_cnt;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable   <= 1'b0;
            flush    <= 1'b0;
            reset_pc <= '0;
            miss_cnt <= '0;
            prdata   <= '0;
        end else begin
            // One-cycle pulse
            flush <= wr_en && (paddr == CSR_CTRL) && pwdata[CTRL_FLUSH];
            if (wr_en && paddr == CSR_CTRL) begin
                enable <= pwdata[CTRL_ENABLE];
            end
            if (wr_en && paddr == CSR_RESET_PC) begin
                reset_pc <= pwdata;
            end
            // Read-only, bumps once per L2 request
            if (miss) begin
                miss_cnt <= miss_cnt + 32'd1;
            end
            if (rd_en) begin
                prdata <= rd_mux;
            end
        end
    end

endmodule

//--- design/fe.sv
`timescale 1ns/1ps

module fe import fe_instr_pkg::*, fe_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,

    output logic              l2_req_valid,
    output t_line_addr        l2_req_line,
    input  logic              l2_rsp_valid,
    input  t_line_data        l2_rsp_data,

    input  t_redirect_pkt     br_mispred,
    input  t_redirect_pkt     nuke,
    input  logic              resume_fetch,

    input  logic              decode_ready,
    output logic              valid_fe1,
    output t_instr_pkt        instr_fe1
);

    logic enable;
    logic flush;
    t_pc  reset_pc;
    logic miss;

    fe_fetch_if fetch_if ();
    fe_line_if  line_if ();

    fe_csr fe_csr (
        .clk, .rst,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .miss, .enable, .flush, .reset_pc
    );

    fe_ctl fe_ctl (
        .clk, .rst, .enable, .reset_pc,
        .br_mispred, .nuke, .resume_fetch,
        .fetch (fetch_if.ctl)
    );

    fe_buf fe_buf (
        .clk, .rst,
        .fetch (fetch_if.fbuf),
        .line  (line_if.fbuf),
        .decode_ready, .valid_fe1, .instr_fe1
    );

    icache icache (
        .clk, .rst, .flush,
        .line (line_if.cache),
        .l2_req_valid, .l2_req_line, .l2_rsp_valid, .l2_rsp_data,
        .miss
    );

endmodule

//--- test/fe_chk.sv
`timescale 1ns/1ps

module fe_chk import fe_instr_pkg::*, fe_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    input  logic              pready,
    input  logic              l2_req_valid,
    input  t_redirect_pkt     br_mispred,
    input  t_redirect_pkt     nuke,
    input  logic              resume_fetch,
    input  logic              decode_ready,
    input  logic              valid_fe1,
    input  t_instr_pkt        instr_fe1,
    input  t_rv_instr         exp_instr,
    output t_pc               exp_pc,
    output int                errors,
    output int                accepted,
    output int                misses
);

    logic       enabled;
    logic       halted;
    t_pc        reset_pc;
    logic       stall_q;
    t_instr_pkt held;
    logic       apb_wr;

    // APB write lands in the access phase
    assign apb_wr = psel && penable && pwrite;

    always @(posedge clk) begin : compare
        t_pc next_pc;
        int  errs;
        next_pc = exp_pc;
        errs    = 0;
        if (rst) begin
            exp_pc   <= '0;
            errors   <= 0;
            accepted <= 0;
            misses   <= 0;
            enabled  <= 1'b0;
            halted   <= 1'b0;
            reset_pc <= '0;
            stall_q  <= 1'b0;
        end else begin
            if (l2_req_valid) begin
                misses <= misses + 1;
            end
            // Zero wait states, every access phase completes
            if (psel && penable && pready !== 1'b1) begin
                $display("CHECK FAILED pready expected %h actual %h", 1'b1, pready);
                errs++;
            end
            // Stalled output must not move
            if (stall_q && instr_fe1 !== held) begin
                $display("CHECK FAILED instr_fe1 expected %h actual %h", held, instr_fe1);
                errs++;
            end
            stall_q <= valid_fe1 && !decode_ready;
            held    <= instr_fe1;
            // Decode takes the instruction
            if (valid_fe1 && decode_ready) begin
                if (instr_fe1.pc !== exp_pc) begin
                    $display("CHECK FAILED instr_fe1.pc expected %h actual %h",
                             exp_pc, instr_fe1.pc);
                    errs++;
                end
                if (instr_fe1.instr !== exp_instr) begin
                    $display("CHECK FAILED instr_fe1.instr expected %h actual %h",
                             exp_instr, instr_fe1.instr);
                    errs++;
                end
                accepted <= accepted + 1;
                next_pc = exp_pc + PC_STEP;
            end
            // Register writes seen on the bus
            if (apb_wr && paddr == CSR_RESET_PC) begin
                reset_pc <= pwdata;
            end
            if (apb_wr && paddr == CSR_CTRL) begin
                enabled <= pwdata[CTRL_ENABLE];
                // Rising enable restarts at the reset PC
                if (pwdata[CTRL_ENABLE] && !enabled) begin
                    next_pc = reset_pc;
                end
            end
            // Nuke beats mispredict, halted front end ignores mispredicts
            if (enabled && nuke.valid) begin
                next_pc = nuke.pc;
                halted <= 1'b1;
            end else if (enabled && !halted && br_mispred.valid) begin
                next_pc = br_mispred.pc;
            end else if (halted && resume_fetch) begin
                halted <= 1'b0;
            end
            exp_pc <= next_pc;
            errors <= errors + errs;
        end
    end

endmodule

//--- test/fe_tb.sv
`timescale 1ns/1ps

module fe_tb import fe_instr_pkg::*, fe_mem_pkg::*; ();

    localparam int unsigned SEED     = 32'h963b9fa4;
    localparam int          WAIT_MAX = 3000;
    localparam t_pc         BASE_PC  = 32'h0000_1000;

    logic              clk = 1'b0;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              l2_req_valid;
    t_line_addr        l2_req_line;
    logic              l2_rsp_valid = 1'b0;
    t_line_data        l2_rsp_data = '0;
    t_redirect_pkt     br_mispred;
    t_redirect_pkt     nuke;
    logic              resume_fetch;
    logic              decode_ready = 1'b0;
    logic              valid_fe1;
    t_instr_pkt        instr_fe1;

    t_pc        exp_pc;
    t_rv_instr  exp_instr;
    int         chk_errors;
    int         acc_cnt;
    int         miss_cnt;
    int         tb_errors;
    int         tests_run;
    int         tests_failed;
    int         err_mark;
    int         errs;
    int         c0;
    int         c1;
    t_pc        tgt;
    t_pc        nuke_pc;
    logic       l2_busy = 1'b0;
    int         l2_delay;
    t_line_addr l2_line;

    fe uut (.*);

    fe_chk chk (.*, .errors(chk_errors), .accepted(acc_cnt), .misses(miss_cnt));

    always #50 clk = ~clk;

    // Instruction word stored at a byte address
    function automatic t_rv_instr instr_of(t_pc pc);
        return (pc * 32'h9e37_79b1) ^ {pc[15:0], pc[31:16]} ^ 32'h0000_0013;
    endfunction

    // Word k holds the instruction at line base + 4k
    function automatic t_line_data line_of(t_line_addr la);
        t_line_data d;
        t_pc        base;
        int         k;
        base = t_pc'(la) << LINE_OFF_W;
        for (k = 0; k < INSTRS_PER_LINE; k++) begin
            d[k*32 +: 32] = instr_of(base + t_pc'(4 * k));
        end
        return d;
    endfunction

    assign exp_instr = instr_of(exp_pc);

    // Decode stalls about a third of the time
    always @(posedge clk) begin
        decode_ready <= ($urandom % 3) != 0;
    end

    // L2 answers after 1 to 6 cycles
    always @(posedge clk) begin
        if (rst) begin
            l2_rsp_valid <= 1'b0;
            l2_busy      <= 1'b0;
        end else begin
            l2_rsp_valid <= 1'b0;
            if (l2_req_valid) begin
                l2_busy  <= 1'b1;
                l2_line  <= l2_req_line;
                l2_delay <= 1 + ($urandom % 6);
            end else if (l2_busy) begin
                if (l2_delay <= 1) begin
                    l2_busy      <= 1'b0;
                    l2_rsp_valid <= 1'b1;
                    l2_rsp_data  <= line_of(l2_line);
                end else begin
                    l2_delay <= l2_delay - 1;
                end
            end
        end
    end

    task automatic fail_timeout(input string what);
        $display("TIMEOUT: %s", what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // prdata registered at the setup edge
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [APB_AW-1:0] addr,
                             input logic [31:0] exp);
        logic [31:0] got;
        read_reg(addr, got);
        if (got !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, got);
            tb_errors++;
        end
    endtask

    task automatic send_mispredict(input t_pc pc);
        @(posedge clk);
        br_mispred <= {1'b1, pc};
        @(posedge clk);
        br_mispred <= '0;
    endtask

    task automatic send_nuke(input t_pc pc);
        @(posedge clk);
        nuke <= {1'b1, pc};
        @(posedge clk);
        nuke <= '0;
    endtask

    task automatic pulse_resume();
        @(posedge clk);
        resume_fetch <= 1'b1;
        @(posedge clk);
        resume_fetch <= 1'b0;
    endtask

    // Until decode has taken n more instructions
    task automatic await_outputs(input int n);
        int target;
        int cycles;
        target = acc_cnt + n;
        cycles = 0;
        while (acc_cnt < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_MAX) begin
                fail_timeout("decode received too few instructions");
            end
        end
    endtask

    // No L2 traffic for eight cycles in a row
    task automatic await_l2_idle();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 8) begin
            @(posedge clk);
            cycles++;
            quiet = (l2_busy || l2_req_valid || l2_rsp_valid) ? 0 : quiet + 1;
            if (cycles > WAIT_MAX) begin
                fail_timeout("the L2 port never went quiet");
            end
        end
    endtask

    // First valid output must carry pc
    task automatic check_first_pc(input t_pc pc);
        int cycles;
        cycles = 0;
        // Outputs settled after the redirect edge
        @(negedge clk);
        while (!valid_fe1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_MAX) begin
                fail_timeout("no instruction came out after the redirect");
            end
        end
        if (instr_fe1.pc !== pc) begin
            $display("CHECK FAILED instr_fe1.pc expected %h actual %h", pc, instr_fe1.pc);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int total;
        @(negedge clk);
        total = chk_errors + tb_errors;
        tests_run++;
        if (total != err_mark) begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, total - err_mark);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
        err_mark = total;
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        br_mispred   = '0;
        nuke         = '0;
        resume_fetch = 1'b0;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Reset values and RESET_PC readback
        check_reg("CTRL", CSR_CTRL, 32'h0);
        check_reg("MISSES", CSR_MISSES, 32'h0);
        write_reg(CSR_RESET_PC, BASE_PC);
        check_reg("RESET_PC", CSR_RESET_PC, BASE_PC);
        end_test("register reset and readback");

        // Six lines, sets 0 to 5
        write_reg(CSR_CTRL, 32'h1 << CTRL_ENABLE);
        await_outputs(24);
        end_test("straight-line fetch");

        // Lines 0 and 1 refetched from the cache
        send_nuke(BASE_PC);
        await_l2_idle();
        c0 = miss_cnt;
        check_reg("MISSES", CSR_MISSES, c0);
        pulse_resume();
        await_outputs(8);
        nuke_pc = 32'h0008_0000 | ($urandom & 32'h0000_fffc);
        send_nuke(nuke_pc);
        await_l2_idle();
        check_reg("MISSES", CSR_MISSES, c0);
        if (miss_cnt != c0) begin
            $display("CHECK FAILED l2_req_valid count expected %h actual %h", c0, miss_cnt);
            tb_errors++;
        end
        end_test("miss count and cache reuse");

        // Running from the nuke PC, then halted again
        pulse_resume();
        await_outputs(4);
        send_nuke(nuke_pc);
        repeat (20) begin
            @(negedge clk);
            if (valid_fe1) begin
                $display("CHECK FAILED valid_fe1 expected %h actual %h", 1'b0, valid_fe1);
                tb_errors++;
            end
        end
        pulse_resume();
        check_first_pc(nuke_pc);
        await_outputs(6);
        end_test("nuke and resume");

        tgt = 32'h0004_0000 | ($urandom & 32'h0003_fffc);
        send_mispredict(tgt);
        check_first_pc(tgt);
        await_outputs(12);
        end_test("branch mispredict");

        // Lines 0 and 1 cached, front end parked at BASE_PC
        send_mispredict(BASE_PC);
        check_first_pc(BASE_PC);
        await_outputs(8);
        send_nuke(BASE_PC);
        await_l2_idle();
        c1 = miss_cnt;
        // Flush keeps enable set
        write_reg(CSR_CTRL, (32'h1 << CTRL_ENABLE) | (32'h1 << CTRL_FLUSH));
        pulse_resume();
        check_first_pc(BASE_PC);
        await_outputs(8);
        if (miss_cnt < c1 + 2) begin
            $display("CHECK FAILED l2_req_valid count expected %h actual %h", c1 + 2, miss_cnt);
            tb_errors++;
        end
        end_test("flush and refetch");

        errs = chk_errors + tb_errors;
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errs);
        if (errs == 0 && tests_failed == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
design/fe_instr_pkg.sv
design/fe_mem_pkg.sv
design/fe_if.sv
design/fe_ctl.sv
design/fe_buf.sv
design/icache.sv
design/fe_csr.sv
design/fe.sv
test/fe_chk.sv
test/fe_tb.sv
